/* bench/tb_mini_uart.sv */
`timescale 1ns/1ps

`include "uart_consts.svh"

module tb_mini_uart
    import uart_pkg::*;
();

    localparam int CLK_NS     = 4;
    localparam int BIT_CYC    = 16;   // divt, clocks per serial bit
    localparam int RX_DIV     = 2;    // divr, 8 samples per bit
    localparam int NUM_RANDOM = 20;
    // framing 2, busy test 3, rx 1, two glitch windows, random both ways
    localparam int NUM_FRAMES = 8 + 2 * NUM_RANDOM;
    // old 9600 divisor has to drain before the new one loads
    localparam int WATCHDOG_NS = (NUM_FRAMES * 12 * BIT_CYC + `BAUD_SND_9600) * CLK_NS * 2;
    localparam bus_data_t LSR_IDLE = 32'h1 << `UART_LSR_TX_IDLE;

    logic      CLK_I;
    logic      RST_I;
    reg_addr_t ADD_I;
    bus_data_t DAT_I;
    bus_data_t DAT_O;
    logic      STB_I;
    logic      WE_I;
    logic      ACK_O;
    logic      IRQ_O;
    logic      rxd;
    logic      txd;

    integer    seed;
    byte_t     tx_queue [$];   // bytes written, not yet seen on txd
    byte_t     rx_queue [$];   // bytes driven on rxd, not yet read

    mini_uart DUT (.*);

    initial begin
        CLK_I = 1'b0;
        forever #(CLK_NS / 2) CLK_I = ~CLK_I;
    end

    ////////////////////////////////////////////////////////////
    // failure reporting
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_error("watchdog expired, the run took too long");
    end

    // bus protocol, sampled at posedge where bench inputs are settled
    assert property (@(posedge CLK_I) disable iff (RST_I) ACK_O == STB_I)
        else report_mismatch("ACK_O does not follow STB_I");
    assert property (@(posedge CLK_I) disable iff (RST_I) !STB_I |-> DAT_O == '0)
        else report_mismatch("DAT_O not zero outside a strobe");

    ////////////////////////////////////////////////////////////
    // bus tasks, drive on falling edge
    ////////////////////////////////////////////////////////////

    task automatic bus_write(input reg_addr_t addr, input bus_data_t data);
        @(negedge CLK_I);
        ADD_I = addr;
        DAT_I = data;
        WE_I  = 1'b1;
        STB_I = 1'b1;
        @(negedge CLK_I);   // write landed on the posedge in between
        STB_I = 1'b0;
        WE_I  = 1'b0;
        DAT_I = '0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output bus_data_t data);
        @(negedge CLK_I);
        ADD_I = addr;
        WE_I  = 1'b0;
        STB_I = 1'b1;
        #1;
        data = DAT_O;   // mid low phase, settled
        @(negedge CLK_I);
        STB_I = 1'b0;
    endtask

    task automatic read_expect(input reg_addr_t addr, input bus_data_t exp, input string what);
        bus_data_t got;
        bus_read(addr, got);
        assert (got == exp)
            else report_mismatch($sformatf("%s read %h, expected %h", what, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // serial side
    ////////////////////////////////////////////////////////////

    // samples each bit centre, checks lsr tx idle low meanwhile
    task automatic decode_frame(output byte_t data);
        int        waited;
        bus_data_t st;
        waited = 0;
        data   = '0;
        while (txd !== 1'b0) begin   // hunt for start edge
            @(negedge CLK_I);
            waited++;
            if (waited > 3 * BIT_CYC) report_error("no start bit appeared on txd");
        end
        repeat (BIT_CYC / 2) @(negedge CLK_I);
        for (int i = 0; i < 10; i++) begin
            if (i == 0) begin
                assert (txd == 1'b0) else report_mismatch("start bit not low at centre");
            end else if (i == 9) begin
                assert (txd == 1'b1) else report_mismatch("stop bit not high");
            end else begin
                data[i-1] = txd;   // lsb first
            end
            bus_read(`OFF_UART_LSR, st);   // takes two of the sixteen cycles
            assert (st[`UART_LSR_TX_IDLE] == 1'b0)
                else report_mismatch($sformatf("tx idle set during bit %0d", i));
            if (i < 9) repeat (BIT_CYC - 2) @(negedge CLK_I);
        end
    endtask

    task automatic wait_tx_idle();
        bus_data_t st;
        int        polls;
        polls = 0;
        st    = '0;
        while (st[`UART_LSR_TX_IDLE] !== 1'b1) begin
            bus_read(`OFF_UART_LSR, st);
            polls++;
            if (polls > BIT_CYC) report_error("transmitter never returned to idle");
        end
    endtask

    task automatic transmit_byte(input byte_t data);
        byte_t got;
        byte_t exp;
        tx_queue.push_back(data);
        bus_write(`OFF_UART_DATA, {24'd0, data});
        decode_frame(got);
        exp = tx_queue.pop_front();
        assert (got == exp)
            else report_mismatch($sformatf("txd byte %h, expected %h", got, exp));
        wait_tx_idle();
    endtask

    task automatic drive_frame(input byte_t data);
        @(negedge CLK_I);
        rxd = 1'b0;   // start
        repeat (BIT_CYC) @(negedge CLK_I);
        for (int i = 0; i < 8; i++) begin
            rxd = data[i];
            repeat (BIT_CYC) @(negedge CLK_I);
        end
        rxd = 1'b1;   // stop, then line idles
        repeat (BIT_CYC) @(negedge CLK_I);
    endtask

    task automatic receive_byte(input byte_t data);
        bus_data_t rd;
        byte_t     exp;
        int        waited;
        rx_queue.push_back(data);
        drive_frame(data);
        waited = 0;
        while (IRQ_O !== 1'b1) begin
            @(negedge CLK_I);
            waited++;
            if (waited > BIT_CYC) report_error("IRQ_O did not rise after a received frame");
        end
        bus_read(`OFF_UART_LSR, rd);
        assert (rd[`UART_LSR_RX_READY] == 1'b1) else report_mismatch("rx ready not set");
        bus_read(`OFF_UART_DATA, rd);
        exp = rx_queue.pop_front();
        assert (rd == {24'd0, exp})
            else report_mismatch($sformatf("rx data %h, expected %h", rd, exp));
        assert (IRQ_O == 1'b0) else report_mismatch("IRQ_O still high after data read");
        read_expect(`OFF_UART_LSR, LSR_IDLE, "lsr after data read");
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        RST_I = 1'b1;
        ADD_I = '0;
        DAT_I = '0;
        STB_I = 1'b0;
        WE_I  = 1'b0;
        rxd   = 1'b1;   // mark
        seed  = 32'h7610102d;
        repeat (8) @(posedge CLK_I);
        @(negedge CLK_I);
        RST_I = 1'b0;

        // reset state
        assert (txd == 1'b1 && IRQ_O == 1'b0) else report_mismatch("serial side after reset");
        read_expect(`OFF_UART_LSR, LSR_IDLE, "lsr after reset");
        read_expect(`OFF_UART_DIVR, `BAUD_RCV_9600, "divr default");
        read_expect(`OFF_UART_DIVT, `BAUD_SND_9600, "divt default");

        // register access, upper data bits ignored
        bus_write(`OFF_UART_DIVT, 32'hbeef_0000 | BIT_CYC);
        bus_write(`OFF_UART_DIVR, RX_DIV);
        read_expect(`OFF_UART_DIVT, BIT_CYC, "divt");
        read_expect(`OFF_UART_DIVR, RX_DIV, "divr");
        for (int a = 4; a < 8; a++) read_expect(reg_addr_t'(a), '0, "unmapped");
        repeat (`BAUD_SND_9600 + 2) @(negedge CLK_I);   // past the old counter wrap

        // framing
        transmit_byte(8'h5a);
        transmit_byte(8'h81);

        // second write while busy is lost
        tx_queue.push_back(8'h3c);
        bus_write(`OFF_UART_DATA, 32'h3c);
        bus_write(`OFF_UART_DATA, 32'hc3);
        begin
            byte_t got;
            byte_t exp;
            decode_frame(got);
            exp = tx_queue.pop_front();
            assert (got == exp)
                else report_mismatch($sformatf("busy test sent %h, expected %h", got, exp));
        end
        wait_tx_idle();
        repeat (2 * BIT_CYC) begin
            @(negedge CLK_I);
            assert (txd == 1'b1) else report_mismatch("dropped write reached txd");
        end
        transmit_byte(8'h96);

        // receive, then one-cycle glitches on both rx tick phases
        receive_byte(8'ha7);
        for (int g = 0; g < 2; g++) begin
            repeat (g + 1) @(negedge CLK_I);   // odd spacing between the two glitches
            rxd = 1'b0;
            @(negedge CLK_I);
            rxd = 1'b1;
            repeat (12 * BIT_CYC) begin   // a false frame would finish in here
                @(negedge CLK_I);
                assert (IRQ_O == 1'b0) else report_mismatch("glitch on rxd raised IRQ_O");
            end
        end

        // random traffic
        repeat (NUM_RANDOM) transmit_byte(byte_t'($random(seed)));
        repeat (NUM_RANDOM) receive_byte(byte_t'($random(seed)));

        $display("all tests passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hw
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_regs.sv
hw/mini_uart.sv
bench/tb_mini_uart.sv

/* hw/mini_uart.sv */
`timescale 1ns/1ps

module mini_uart
    import uart_pkg::*;
(
    input  logic      CLK_I,
    input  logic      RST_I,
    input  reg_addr_t ADD_I,    // word address
    input  bus_data_t DAT_I,
    output bus_data_t DAT_O,
    input  logic      STB_I,
    input  logic      WE_I,
    output logic      ACK_O,
    output logic      IRQ_O,    // byte waiting
    input  logic      rxd,
    output logic      txd
);

    divisor_t divr;
    divisor_t divt;
    byte_t    tx_byte;
    logic     tx_load;
    logic     tx_idle;
    byte_t    rx_byte;
    logic     rx_ready;
    logic     rx_read;
    logic     rx_tick;
    logic     tx_tick;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    uart_regs u_regs (
        .CLK_I    (CLK_I),
        .RST_I    (RST_I),
        .ADD_I    (ADD_I),
        .DAT_I    (DAT_I),
        .STB_I    (STB_I),
        .WE_I     (WE_I),
        .DAT_O    (DAT_O),
        .ACK_O    (ACK_O),
        .divr     (divr),
        .divt     (divt),
        .tx_byte  (tx_byte),
        .tx_load  (tx_load),
        .tx_idle  (tx_idle),
        .rx_read  (rx_read),
        .rx_byte  (rx_byte),
        .rx_ready (rx_ready)
    );

    uart_baud_gen u_baud (
        .CLK_I   (CLK_I),
        .RST_I   (RST_I),
        .divr    (divr),
        .divt    (divt),
        .rx_tick (rx_tick),
        .tx_tick (tx_tick)
    );

    uart_rx u_rx (
        .CLK_I    (CLK_I),
        .RST_I    (RST_I),
        .rxd      (rxd),
        .rx_tick  (rx_tick),
        .rx_read  (rx_read),
        .rx_byte  (rx_byte),
        .rx_ready (rx_ready)
    );

    uart_tx u_tx (
        .CLK_I   (CLK_I),
        .RST_I   (RST_I),
        .tx_byte (tx_byte),
        .tx_load (tx_load),
        .tx_tick (tx_tick),
        .txd     (txd),
        .tx_idle (tx_idle)
    );

    assign IRQ_O = rx_ready;   // level irq until the data read

endmodule

/* hw/uart_baud_gen.sv */
`timescale 1ns/1ps

module uart_baud_gen
    import uart_pkg::*;
(
    input  logic     CLK_I,
    input  logic     RST_I,
    input  divisor_t divr,      // clocks per rx sample tick
    input  divisor_t divt,      // clocks per tx bit tick
    output logic     rx_tick,
    output logic     tx_tick
);

    // channel 0 is rx, channel 1 is tx
    divisor_t div_eff [2];
    divisor_t cnt     [2];
    logic     tick    [2];

    // zero divisor behaves like one, tick every clock
    always_comb begin
        div_eff[0] = (divr == '0) ? divisor_t'(1) : divr;
        div_eff[1] = (divt == '0) ? divisor_t'(1) : divt;
    end

    ////////////////////////////////////////////////////////////
    // down-counters
    ////////////////////////////////////////////////////////////

    // reload at one (or at zero straight out of reset)
    // so the period is exactly div_eff clocks
    always_ff @(posedge CLK_I or posedge RST_I) begin
        if (RST_I) begin
            for (int i = 0; i < 2; i++) begin
                cnt[i]  <= '0;      // first cycle just loads
                tick[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cnt[i] <= divisor_t'(1)) begin
                    cnt[i] <= div_eff[i];   // new divisor picked up here
                end else begin
                    cnt[i] <= cnt[i] - divisor_t'(1);
                end
                tick[i] <= (cnt[i] == divisor_t'(1));   // one-cycle pulse
            end
        end
    end

    assign rx_tick = tick[0];
    assign tx_tick = tick[1];

endmodule

/* hw/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

////////////////////////////////////////////////////////////
// register map, word offsets on ADD_I[4:2]
////////////////////////////////////////////////////////////

`define OFF_UART_DATA 3'd0   // tx write / rx read
`define OFF_UART_LSR 3'd1    // line status, read only
`define OFF_UART_DIVR 3'd2   // rx sample divisor
`define OFF_UART_DIVT 3'd3   // tx bit divisor

// line status bit positions
`define UART_LSR_RX_READY 0
`define UART_LSR_TX_IDLE 5

////////////////////////////////////////////////////////////
// timing
////////////////////////////////////////////////////////////

`define UART_RX_OVERSAMPLE 8   // rx ticks per bit, power of two
`define UART_CLK_HZ 50000000   // 50 MHz core clock

// cycles per bit at 9600 baud, tx runs at bit rate
`define BAUD_SND_9600 (`UART_CLK_HZ / 9600)
// rx runs oversampled
`define BAUD_RCV_9600 (`BAUD_SND_9600 / `UART_RX_OVERSAMPLE)

`endif

/* hw/uart_pkg.sv */
package uart_pkg;

    typedef logic [7:0]  byte_t;       // one serial byte
    typedef logic [15:0] divisor_t;    // clocks per tick
    typedef logic [2:0]  reg_addr_t;   // word address, ADD_I[4:2]
    typedef logic [31:0] bus_data_t;   // bus data word

    // transmit FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,   // loaded, waiting for tick to drop the line
        TX_DATA,    // data bits, then the stop bit
        TX_STOP     // holding stop for one full period
    } tx_state_e;

    // receive FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,   // low seen, confirming at half bit
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

/* hw/uart_regs.sv */
`timescale 1ns/1ps

`include "uart_consts.svh"

module uart_regs
    import uart_pkg::*;
(
    input  logic      CLK_I,
    input  logic      RST_I,
    // bus slave
    input  reg_addr_t ADD_I,
    input  bus_data_t DAT_I,
    input  logic      STB_I,
    input  logic      WE_I,
    output bus_data_t DAT_O,
    output logic      ACK_O,
    // baud generator
    output divisor_t  divr,
    output divisor_t  divt,
    // transmitter
    output byte_t     tx_byte,
    output logic      tx_load,
    input  logic      tx_idle,
    // receiver
    output logic      rx_read,
    input  byte_t     rx_byte,
    input  logic      rx_ready
);

    logic      bus_wr;
    logic      bus_rd;
    logic      sel_data;
    logic      tx_free;    // idle and no load in flight
    bus_data_t lsr;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    assign ACK_O    = STB_I;   // zero wait state
    assign bus_wr   = STB_I & WE_I;
    assign bus_rd   = STB_I & ~WE_I;
    assign sel_data = (ADD_I == `OFF_UART_DATA);

    // the load cycle still sees tx_idle high, mask it
    assign tx_free = tx_idle & ~tx_load;

    ////////////////////////////////////////////////////////////
    // writable registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I or posedge RST_I) begin
        if (RST_I) begin
            divr <= divisor_t'(`BAUD_RCV_9600);
            divt <= divisor_t'(`BAUD_SND_9600);
        end else if (bus_wr) begin
            if (ADD_I == `OFF_UART_DIVR) divr <= DAT_I[15:0];
            if (ADD_I == `OFF_UART_DIVT) divt <= DAT_I[15:0];
        end
    end

    // busy writes are dropped, software polls lsr first
    always_ff @(posedge CLK_I) begin
        if (bus_wr && sel_data && tx_free) begin
            tx_byte <= DAT_I[7:0];
        end
    end

    // one cycle after the accepted write
    always_ff @(posedge CLK_I or posedge RST_I) begin
        if (RST_I) begin
            tx_load <= 1'b0;
        end else begin
            tx_load <= bus_wr & sel_data & tx_free;
        end
    end

    // data read acks the received byte, drops irq next cycle
    assign rx_read = bus_rd & sel_data;

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////

    always_comb begin
        lsr                     = '0;
        lsr[`UART_LSR_RX_READY] = rx_ready;
        lsr[`UART_LSR_TX_IDLE]  = tx_free;
    end

    always_comb begin
        DAT_O = '0;   // quiet bus outside a strobe
        if (STB_I) begin
            case (ADD_I)
                `OFF_UART_DATA: DAT_O = {24'd0, rx_byte};
                `OFF_UART_LSR:  DAT_O = lsr;
                `OFF_UART_DIVR: DAT_O = {16'd0, divr};
                `OFF_UART_DIVT: DAT_O = {16'd0, divt};
                default:        DAT_O = '0;   // 4..7 unmapped
            endcase
        end
    end

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ps

`include "uart_consts.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic  CLK_I,
    input  logic  RST_I,
    input  logic  rxd,        // async serial in
    input  logic  rx_tick,    // oversample tick
    input  logic  rx_read,    // bus read of data reg
    output byte_t rx_byte,
    output logic  rx_ready
);

    localparam int unsigned OVS   = `UART_RX_OVERSAMPLE;
    localparam int unsigned CNT_W = $clog2(OVS);

    logic             rxd_meta;
    logic             rxd_sync;
    rx_state_e        state;
    logic [CNT_W-1:0] smp_cnt;    // ticks within the current bit
    logic [2:0]       bit_cnt;    // data bit index
    byte_t            shreg;
    logic             half_pt;
    logic             bit_pt;

    ////////////////////////////////////////////////////////////
    // synchronizer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I or posedge RST_I) begin
        if (RST_I) begin
            rxd_meta <= 1'b1;   // idle line is high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign half_pt = (smp_cnt == CNT_W'(OVS / 2 - 1));   // middle of start bit
    assign bit_pt  = (smp_cnt == CNT_W'(OVS - 1));       // one bit later

    ////////////////////////////////////////////////////////////
    // receive FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I or posedge RST_I) begin
        if (RST_I) begin
            state   <= RX_IDLE;
            smp_cnt <= '0;
            bit_cnt <= '0;
        end else if (rx_tick) begin
            case (state)
                RX_IDLE: begin
                    if (!rxd_sync) begin   // possible start edge
                        state   <= RX_START;
                        smp_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (half_pt) begin
                        smp_cnt <= '0;
                        bit_cnt <= '0;
                        // still low, real start bit, else a glitch
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        smp_cnt <= smp_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_pt) begin
                        smp_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;   // last data bit
                    end else begin
                        smp_cnt <= smp_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_pt) begin
                        smp_cnt <= '0;
                        state   <= RX_IDLE;   // mid stop bit, line already high
                    end else begin
                        smp_cnt <= smp_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge CLK_I) begin
        if (rx_tick && state == RX_DATA && bit_pt) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

    // capture at mid stop, a fresh byte wins over a read
    always_ff @(posedge CLK_I or posedge RST_I) begin
        if (RST_I) begin
            rx_byte  <= '0;
            rx_ready <= 1'b0;
        end else if (rx_tick && state == RX_STOP && bit_pt) begin
            rx_byte  <= shreg;    // overwrites an unread byte
            rx_ready <= 1'b1;
        end else if (rx_read) begin
            rx_ready <= 1'b0;
        end
    end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic  CLK_I,
    input  logic  RST_I,
    input  byte_t tx_byte,
    input  logic  tx_load,    // one-cycle load strobe
    input  logic  tx_tick,    // bit rate tick
    output logic  txd,
    output logic  tx_idle
);

    tx_state_e  state;
    byte_t      shreg;
    logic [3:0] bit_cnt;   // 0..7 data, 8 is the stop bit

    ////////////////////////////////////////////////////////////
    // transmit FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I or posedge RST_I) begin
        if (RST_I) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            txd     <= 1'b1;   // mark level
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_load) state <= TX_START;
                end
                TX_START: begin
                    if (tx_tick) begin
                        txd     <= 1'b0;   // start bit
                        bit_cnt <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (tx_tick) begin
                        if (bit_cnt == 4'd8) begin
                            txd   <= 1'b1;   // stop bit
                            state <= TX_STOP;
                        end else begin
                            txd <= shreg[0];   // lsb first
                        end
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (tx_tick) state <= TX_IDLE;   // stop bit held a full period
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // byte only captured while idle, shifted on each data tick
    always_ff @(posedge CLK_I) begin
        if (state == TX_IDLE && tx_load) begin
            shreg <= tx_byte;
        end else if (state == TX_DATA && tx_tick) begin
            shreg <= {1'b1, shreg[7:1]};
        end
    end

    assign tx_idle = (state == TX_IDLE);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mini_uart testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_mini_uart
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module "$TOP" -o "V$TOP" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see $BUILD_LOG"
    exit 1
fi

"./obj_dir/V$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" "$SIM_LOG"; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED, see $SIM_LOG"
    exit 1
fi
